// File: Bender.yml
package:
  name: bch_dec

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bch_pkg.sv
      - hw/bch_syndrome.sv
      - hw/bch_locator.sv
      - hw/bch_chien.sv
      - hw/bch_decoder.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_bch_decoder.sv

// File: bch_dec.f
+incdir+hw
hw/bch_pkg.sv
hw/bch_syndrome.sv
hw/bch_locator.sv
hw/bch_chien.sv
hw/bch_decoder.sv
tb/tb_bch_decoder.sv

// File: hw/bch_cfg.svh
`ifndef BCH_CFG_SVH
`define BCH_CFG_SVH

// Galois field GF(2^4).
`define BCH_M 4

// Code length 2^m - 1.
`define BCH_N 15

// Message bits per codeword.
`define BCH_K 7

// Correctable errors.
`define BCH_T 2

// x^4 + x + 1.
`define BCH_PRIM_POLY 5'b1_0011

// x^8 + x^7 + x^6 + x^4 + 1.
`define BCH_GEN_POLY 9'b1_1101_0001

`endif

// File: hw/bch_chien.sv
`default_nettype none

`include "bch_cfg.svh"

module bch_chien
	import bch_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  locator_t                     loc,
	input  logic                         loc_valid,
	output logic                         out_bit,
	output logic                         out_valid,
	output logic                         word_done,
	output logic [$clog2(`BCH_T+1)-1:0] err_count,
	output logic                         uncorrectable
);

	localparam int POS_W = $clog2(`BCH_N);
	localparam int CNT_W = $clog2(`BCH_T + 1);
	localparam gf_t GF_ONE = gf_t'(1);

	gf_t              term1;    // sigma1 * x at the current position.
	gf_t              term2;    // sigma2 * x^2 at the current position.
	word_t            word;
	err_kind_t        kind;
	logic [POS_W-1:0] pos;
	logic [CNT_W-1:0] root_cnt;
	logic [CNT_W-1:0] roots_total;
	logic [CNT_W-1:0] degree;
	logic             hit;

	// Position i is evaluated at x = alpha^-i.
	assign hit = (GF_ONE ^ term1 ^ term2) == '0;
	assign roots_total = root_cnt + CNT_W'(hit);    // Includes the current position.

	assign out_bit = word[pos] ^ hit;    // Flip the bit at a root.
	assign word_done = out_valid && (pos == '0);
	assign err_count = roots_total;

	always_comb begin
		case (kind)
			err_one: degree = CNT_W'(1);
			err_two: degree = CNT_W'(2);
			default: degree = '0;
		endcase
	end

	// Fewer roots than the degree means the error pattern is beyond t.
	assign uncorrectable = word_done && ((kind == err_uncorr) || (roots_total != degree));

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			pos <= '0;
			root_cnt <= '0;
		end else if (loc_valid) begin
			out_valid <= 1'b1;    // Replaces any word still streaming.
			pos <= POS_W'(`BCH_N - 1);
			root_cnt <= '0;
		end else if (out_valid) begin
			pos <= pos - 1'b1;
			root_cnt <= roots_total;
			if (pos == '0)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (loc_valid) begin
			term1 <= gf_mul_alpha_pow(loc.sigma1, 1);    // x = alpha^1 for bit 14.
			term2 <= gf_mul_alpha_pow(loc.sigma2, 2);
			word <= loc.word;
			kind <= loc.kind;
		end else if (out_valid) begin
			// One position lower is one power of alpha higher in x.
			term1 <= gf_mul_alpha_pow(term1, 1);
			term2 <= gf_mul_alpha_pow(term2, 2);
		end
	end

	// Output only ever starts from a freshly loaded locator.
	assert property (@(posedge clk) disable iff (rst)
		$rose(out_valid) |-> $past(loc_valid));

endmodule

`default_nettype wire

// File: hw/bch_decoder.sv
`default_nettype none

`include "bch_cfg.svh"

module bch_decoder
	import bch_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         start,
	input  logic                         data_in,
	output logic                         out_bit,
	output logic                         out_valid,
	output logic                         word_done,
	output logic [$clog2(`BCH_T+1)-1:0] err_count,
	output logic                         uncorrectable
);

	syn_set_t syn;
	logic     syn_valid;
	locator_t loc;
	logic     loc_valid;

	// Decode, 15 cycles of input.
	bch_syndrome bch_syndrome_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.data_in   (data_in),
		.syn       (syn),
		.syn_valid (syn_valid)
	);

	// Execute, one cycle.
	bch_locator bch_locator_i (
		.clk       (clk),
		.rst       (rst),
		.syn       (syn),
		.syn_valid (syn_valid),
		.loc       (loc),
		.loc_valid (loc_valid)
	);

	// Result, 15 cycles of output.
	bch_chien bch_chien_i (
		.clk           (clk),
		.rst           (rst),
		.loc           (loc),
		.loc_valid     (loc_valid),
		.out_bit       (out_bit),
		.out_valid     (out_valid),
		.word_done     (word_done),
		.err_count     (err_count),
		.uncorrectable (uncorrectable)
	);

endmodule

`default_nettype wire

// File: hw/bch_locator.sv
`default_nettype none

`include "bch_cfg.svh"

module bch_locator
	import bch_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  syn_set_t syn,
	input  logic     syn_valid,
	output locator_t loc,
	output logic     loc_valid
);

	gf_t       s1_cube;
	gf_t       s3_diff;
	err_kind_t kind;
	gf_t       sigma1;
	gf_t       sigma2;

	// The closed form below is the Peterson solution for two errors only.
	if (`BCH_T != 2) begin : g_t_check
		$error("Direct locator formula supports t=2 only.");
	end

	assign s1_cube = gf_cube(syn.s1);
	assign s3_diff = syn.s3 ^ s1_cube;    // Equals sigma2 * S1 for two errors.

	always_comb begin
		kind = err_none;
		sigma1 = '0;
		sigma2 = '0;
		if (syn.s1 == '0) begin
			if (syn.s3 != '0)
				kind = err_uncorr;    // No locator of degree <= 2 fits.
		end else if (s3_diff == '0) begin
			kind = err_one;
			sigma1 = syn.s1;
		end else begin
			kind = err_two;
			sigma1 = syn.s1;
			sigma2 = gf_mul(s3_diff, gf_inv(syn.s1));
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			loc_valid <= 1'b0;
		else
			loc_valid <= syn_valid;
	end

	always_ff @(posedge clk) begin
		if (syn_valid) begin
			loc.kind <= kind;
			loc.sigma1 <= sigma1;
			loc.sigma2 <= sigma2;
			loc.word <= syn.word;
		end
	end

	// A two-error locator must have full degree or the Chien count breaks.
	assert property (@(posedge clk) disable iff (rst)
		loc_valid && (loc.kind == err_two) |-> loc.sigma2 != '0);

endmodule

`default_nettype wire

// File: hw/bch_pkg.sv
`default_nettype none

`include "bch_cfg.svh"

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_t;      // One field element.
	typedef logic [`BCH_N-1:0] word_t;    // Bit i is the coefficient of x^i.

	typedef enum logic [1:0] {
		err_none,
		err_one,
		err_two,
		err_uncorr
	} err_kind_t;

	typedef struct packed {
		gf_t   s1;
		gf_t   s3;
		word_t word;
	} syn_set_t;

	typedef struct packed {
		err_kind_t kind;
		gf_t       sigma1;
		gf_t       sigma2;
		word_t     word;
	} locator_t;

	// Multiply by alpha, reducing with the primitive polynomial.
	function automatic gf_t gf_xtime(input gf_t a);
		gf_t r;
		r = {a[`BCH_M-2:0], 1'b0};
		if (a[`BCH_M-1])
			r = r ^ gf_t'(`BCH_PRIM_POLY);
		return r;
	endfunction

	function automatic gf_t gf_mul(input gf_t a, input gf_t b);
		gf_t acc;
		gf_t x;
		acc = '0;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ x;    // Add a * alpha^i.
			x = gf_xtime(x);
		end
		return acc;
	endfunction

	function automatic gf_t gf_cube(input gf_t a);
		return gf_mul(a, gf_mul(a, a));
	endfunction

	// a^14 is the inverse since a^15 = 1 for nonzero a.
	function automatic gf_t gf_inv(input gf_t a);
		gf_t a3;
		gf_t a7;
		a3 = gf_cube(a);
		a7 = gf_mul(gf_mul(a3, a3), a);    // a^6 * a.
		return gf_mul(a7, a7);
	endfunction

	// Constant multiply by alpha^p, unrolled to a fixed bound.
	function automatic gf_t gf_mul_alpha_pow(input gf_t a, input int unsigned p);
		gf_t x;
		x = a;
		for (int i = 0; i < `BCH_N; i++) begin
			if (i < p)
				x = gf_xtime(x);
		end
		return x;
	endfunction

endpackage

`default_nettype wire

// File: hw/bch_syndrome.sv
`default_nettype none

`include "bch_cfg.svh"

module bch_syndrome
	import bch_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  logic     data_in,
	output syn_set_t syn,
	output logic     syn_valid
);

	localparam int CNT_W = $clog2(`BCH_N);

	logic [CNT_W-1:0] bit_cnt;    // Bits taken so far in this word.
	logic             busy;
	logic             take;
	logic             last;
	gf_t              bit_in;
	gf_t              s1_base;
	gf_t              s3_base;
	word_t            word_base;

	assign take = start | busy;
	assign last = busy & ~start & (bit_cnt == CNT_W'(`BCH_N - 1));
	assign bit_in = {{(`BCH_M - 1){1'b0}}, data_in};

	// A start pulse drops whatever was accumulated.
	assign s1_base = start ? '0 : syn.s1;
	assign s3_base = start ? '0 : syn.s3;
	assign word_base = start ? '0 : syn.word;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			syn_valid <= 1'b0;
		end else begin
			syn_valid <= last;    // Pulse once the 15th bit is in.
			if (start) begin
				busy <= 1'b1;
				bit_cnt <= CNT_W'(1);
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last)
					busy <= 1'b0;
			end
		end
	end

	// Horner's rule, highest degree first.
	always_ff @(posedge clk) begin
		if (take) begin
			syn.s1 <= gf_mul_alpha_pow(s1_base, 1) ^ bit_in;    // r(alpha).
			syn.s3 <= gf_mul_alpha_pow(s3_base, 3) ^ bit_in;    // r(alpha^3).
			syn.word <= {word_base[`BCH_N-2:0], data_in};
		end
	end

	// Words are at least 15 cycles apart.
	assert property (@(posedge clk) disable iff (rst) syn_valid |=> !syn_valid);

endmodule

`default_nettype wire

// File: tb/tb_bch_decoder.sv
`default_nettype none

`include "bch_cfg.svh"

module tb_bch_decoder
	import bch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CNT_W = $clog2(`BCH_T + 1);
	localparam int LATENCY = 17;    // Start to first output bit.
	// About 60 words at 32 cycles each, with margin.
	localparam int TIMEOUT_CYCLES = 3000;

	typedef struct packed {
		word_t            word;
		logic [CNT_W-1:0] count;
		logic             unc;
		logic [31:0]      first_cycle;
		logic [31:0]      last_cycle;
	} result_t;

	logic             clk;
	logic             rst;
	logic             start;
	logic             data_in;
	logic             out_bit;
	logic             out_valid;
	logic             word_done;
	logic [CNT_W-1:0] err_count;
	logic             uncorrectable;

	int          cycle;
	int          nbits;    // Output bits of the word being gathered.
	result_t     cur;
	result_t     results[$];
	logic [15:0] lfsr;

	bch_decoder bch_decoder_i (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.data_in       (data_in),
		.out_bit       (out_bit),
		.out_valid     (out_valid),
		.word_done     (word_done),
		.err_count     (err_count),
		.uncorrectable (uncorrectable)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the decoder stopped producing words.", cycle);
			$display("Result: FAILED");
			$fatal(1, "Simulation hung.");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s.", name);
		end
	endtask

	// Gathers output words at mid-cycle, where outputs are stable.
	always @(negedge clk) begin
		if (rst) begin
			nbits = 0;
		end else if (out_valid) begin
			if (nbits == 0)
				cur.first_cycle = cycle;
			cur.word = {cur.word[`BCH_N-2:0], out_bit};    // Bit 14 comes first.
			nbits++;
			if (nbits == `BCH_N) begin
				check_value("word_done", word_done, 1);
				cur.last_cycle = cycle;
				cur.count = err_count;
				cur.unc = uncorrectable;
				results.push_back(cur);
				nbits = 0;
			end else begin
				check_value("word_done", word_done, 0);
			end
		end
	end

	// Taps for x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Systematic, data in the top 7 bits, remainder of d(x) * x^8 below.
	function automatic word_t encode(input logic [`BCH_K-1:0] d);
		word_t r;
		r = word_t'(d) << (`BCH_N - `BCH_K);
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
			if (r[i])
				r = r ^ (word_t'(`BCH_GEN_POLY) << (i - (`BCH_N - `BCH_K)));
		end
		return {d, r[`BCH_N-`BCH_K-1:0]};
	endfunction

	task automatic random_codeword(output word_t code);
		logic [31:0] v;
		rand_bits(`BCH_K, v);
		code = encode(v[`BCH_K-1:0]);
	endtask

	// Distinct error positions.
	task automatic random_mask(input int n_err, output word_t mask);
		logic [31:0] v;
		int          p;
		mask = '0;
		for (int k = 0; k < n_err; k++) begin
			do begin
				rand_bits(4, v);
				p = v;
			end while (p >= `BCH_N || mask[p]);
			mask[p] = 1'b1;
		end
	endtask

	// Drives the first n bits of a word, x^14 first.
	task automatic send_bits(input word_t w, input int n, output int t_start);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#10;
			start = (i == 0);
			data_in = w[`BCH_N-1-i];
			if (i == 0)
				t_start = cycle;
		end
	endtask

	task automatic collect_word(output result_t res);
		while (results.size() == 0)
			@(posedge clk);
		res = results.pop_front();
	endtask

	task automatic check_result(input result_t res, input word_t code, input int n_err,
		input int t_start);
		check_value("out_bit word", res.word, code);
		check_value("err_count", res.count, n_err);
		check_value("uncorrectable", res.unc, 0);
		check_value("first bit cycle", res.first_cycle, t_start + LATENCY);
		check_value("word_done cycle", res.last_cycle, t_start + LATENCY + `BCH_N - 1);
	endtask

	task automatic decode_and_check(input word_t code, input word_t mask, input int n_err);
		int      t_start;
		result_t res;
		send_bits(code ^ mask, `BCH_N, t_start);
		collect_word(res);
		check_result(res, code, n_err, t_start);
	endtask

	task automatic test_clean_words();
		word_t code;
		for (int k = 0; k < 10; k++) begin
			random_codeword(code);
			decode_and_check(code, '0, 0);
		end
	endtask

	task automatic test_single_errors();
		word_t code;
		for (int p = 0; p < `BCH_N; p++) begin
			random_codeword(code);
			decode_and_check(code, word_t'(1) << p, 1);
		end
	endtask

	task automatic test_double_errors();
		word_t code;
		word_t mask;
		for (int k = 0; k < 20; k++) begin
			random_codeword(code);
			random_mask(2, mask);
			decode_and_check(code, mask, 2);
		end
	endtask

	// Eight words with no idle cycle, 0 to 2 errors each.
	task automatic test_back_to_back();
		word_t       codes[8];
		int          starts[8];
		word_t       mask;
		result_t     res;
		logic [31:0] prev_last;
		prev_last = '0;
		for (int k = 0; k < 8; k++) begin
			random_codeword(codes[k]);
			random_mask(k % 3, mask);
			send_bits(codes[k] ^ mask, `BCH_N, starts[k]);
		end
		for (int k = 0; k < 8; k++) begin
			collect_word(res);
			check_result(res, codes[k], k % 3, starts[k]);
			if (k > 0)
				check_value("out_valid gap", res.first_cycle, prev_last + 1);    // No idle cycle.
			prev_last = res.last_cycle;
		end
	endtask

	task automatic test_reset_restart();
		word_t code_a;
		word_t code_b;
		word_t code_c;
		word_t mask;
		int    t_start;
		random_codeword(code_a);
		random_codeword(code_b);
		send_bits(code_a, `BCH_N, t_start);
		send_bits(code_b, `BCH_N, t_start);    // Word A is still streaming out.
		@(posedge clk);
		#10;
		rst = 1'b1;    // Word B sits in the locator, word A is one bit from done.
		start = 1'b0;
		@(posedge clk);
		#10;
		rst = 1'b0;
		@(negedge clk);
		check_value("syn_valid", bch_decoder_i.syn_valid, 0);
		check_value("loc_valid", bch_decoder_i.loc_valid, 0);
		check_value("out_valid", out_valid, 0);
		check_value("word_done", word_done, 0);
		check_value("uncorrectable", uncorrectable, 0);
		check_value("words after reset", results.size(), 0);
		random_codeword(code_c);
		random_mask(2, mask);
		decode_and_check(code_c, mask, 2);
	endtask

	task automatic test_restart_no_reset();
		word_t   code_a;
		word_t   code_b;
		word_t   mask;
		int      t_a;
		int      t_b;
		result_t res;
		random_codeword(code_a);
		random_codeword(code_b);
		random_mask(1, mask);
		send_bits(code_a, 7, t_a);
		send_bits(code_b ^ mask, `BCH_N, t_b);    // Start pulse abandons word A.
		collect_word(res);
		check_result(res, code_b, 1, t_b);
		repeat (20)
			@(posedge clk);
		check_value("extra words", results.size(), 0);
		check_value("out_valid", out_valid, 0);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		data_in = 1'b0;
		cycle = 0;
		nbits = 0;
		cur = '0;
		lfsr = 16'd44;
		repeat (5)
			@(posedge clk);
		#10;
		rst = 1'b0;

		test_clean_words();
		test_single_errors();
		test_double_errors();
		test_back_to_back();
		test_reset_restart();
		test_restart_no_reset();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
